//--- logic/flash_pkg.sv
/*
 * flash loader constants: flash windows, IPL length, RAM base
 * request struct for the SPI reader and the RAM write port struct
 */

package flash_pkg;

    // flash byte address seen by the CPU at offset 0
    localparam logic [23:0] flash_user_base = 24'h200000;

    // IPL source window in flash
    localparam logic [23:0] flash_load_base = 24'h200000;

    // number of 32-bit words copied at boot
    localparam logic [13:0] flash_load_words = 14'd32;

    // first RAM word address written by the IPL
    localparam logic [31:0] ram_write_base = 32'd0;

    // width of the CPU byte offset into the flash window
    localparam int cpu_addr_w = 18;

    // standard slow read opcode
    localparam logic [7:0] flash_read_cmd = 8'h03;

    // request to the SPI reader
    typedef struct packed {
        logic [23:0] addr;
        // held until ready pulses
        logic        valid;
        // keep streaming without a new command
        logic        cont;
    } flash_req_t;

    // RAM write port, a write happens when wstrb is nonzero
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  wstrb;
    } ram_wr_t;

endpackage

//--- logic/spi_flash_reader.sv
/*
 * SPI mode-0 flash reader: command 0x03, 24-bit address, 32-bit words
 * consecutive words with cont set are streamed without a new command
 */

`timescale 1ns/1ps

module spi_flash_reader import flash_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  flash_req_t  req,
    output logic        ready,
    output logic [31:0] rdata,
    output logic        flash_sck,
    output logic        flash_csn,
    output logic        flash_mosi,
    input  logic        flash_miso
);

    typedef enum logic [2:0] {st_idle, st_cmd, st_addr, st_data, st_desel} state_t;

    state_t      state;
    logic [31:0] out_shift;
    logic [31:0] in_shift;
    logic [4:0]  bit_cnt;
    logic [23:0] next_addr;
    logic        stream_open;

    logic shifting;
    logic rise;
    logic fall;
    logic accept;
    logic can_continue;
    logic word_done;

    assign shifting = state inside {st_cmd, st_addr, st_data};
    // sck is registered, so these mark the edge being produced this cycle
    assign rise = shifting && !flash_sck;
    assign fall = shifting && flash_sck;
    // the ready cycle still shows the old request, skip it
    assign accept = (state == st_idle) && req.valid && !ready;
    assign can_continue = stream_open && req.cont && (req.addr == next_addr);
    assign word_done = (state == st_data) && fall && (bit_cnt == 5'd31);

    // msb first, opcode then address
    assign flash_mosi = out_shift[31];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            flash_csn <= 1'b1;
            flash_sck <= 1'b0;
            ready <= 1'b0;
            stream_open <= 1'b0;
            bit_cnt <= 5'd0;
            out_shift <= 32'd0;
        end else begin
            ready <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        bit_cnt <= 5'd0;
                        if (can_continue) begin
                            // csn still low, just clock the next word
                            state <= st_data;
                        end else if (stream_open) begin
                            // close the old stream before a new command
                            state <= st_desel;
                            flash_csn <= 1'b1;
                            stream_open <= 1'b0;
                        end else begin
                            state <= st_cmd;
                            flash_csn <= 1'b0;
                            out_shift <= {flash_read_cmd, req.addr};
                        end
                    end
                end
                st_cmd, st_addr: begin
                    flash_sck <= !flash_sck;
                    if (fall) begin
                        out_shift <= out_shift << 1;
                        bit_cnt <= bit_cnt + 5'd1;
                        if (state == st_cmd && bit_cnt == 5'd7) begin
                            state <= st_addr;
                            bit_cnt <= 5'd0;
                        end else if (state == st_addr && bit_cnt == 5'd23) begin
                            state <= st_data;
                            bit_cnt <= 5'd0;
                        end
                    end
                end
                st_data: begin
                    flash_sck <= !flash_sck;
                    if (fall) begin
                        bit_cnt <= bit_cnt + 5'd1;
                    end
                    if (word_done) begin
                        ready <= 1'b1;
                        bit_cnt <= 5'd0;
                        if (req.cont) begin
                            state <= st_idle;
                            stream_open <= 1'b1;
                        end else begin
                            state <= st_desel;
                            flash_csn <= 1'b1;
                        end
                    end
                end
                st_desel: begin
                    // two cycles high here, idle adds at least one more
                    bit_cnt <= bit_cnt + 5'd1;
                    if (bit_cnt == 5'd1) begin
                        state <= st_idle;
                        bit_cnt <= 5'd0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // address a continued read must ask for
        if (accept) begin
            next_addr <= req.addr + 24'd4;
        end
        // miso sampled as sck rises
        if (state == st_data && rise) begin
            in_shift <= {in_shift[30:0], flash_miso};
        end
        // first byte on the wire lands in bits 7:0
        if (word_done) begin
            rdata <= {in_shift[7:0], in_shift[15:8], in_shift[23:16], in_shift[31:24]};
        end
    end

    // chip select must not glitch high while bits are moving
    assert property (@(posedge clk) disable iff (reset)
        (state inside {st_cmd, st_addr, st_data}) |-> !flash_csn);

endmodule

//--- logic/boot_loader.sv
/*
 * IPL sequencer: streams flash_load_words words from flash_load_base
 * and writes them to RAM from ram_write_base, then drops dma_busy
 */

`timescale 1ns/1ps

module boot_loader import flash_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        flash_ready,
    input  logic [31:0] flash_rdata,
    output flash_req_t  load_req,
    output ram_wr_t     ram_wr,
    output logic        dma_busy
);

    logic [23:0] read_index;
    logic [13:0] word_count;
    logic [31:0] write_addr;
    logic [3:0]  wstrb;
    logic        loading;

    always_ff @(posedge clk) begin
        if (reset) begin
            read_index <= flash_load_base;
            word_count <= 14'd0;
            write_addr <= ram_write_base;
            wstrb <= 4'b0000;
            loading <= 1'b1;
            dma_busy <= 1'b1;
        end else begin
            wstrb <= 4'b0000;
            // bus handed back one cycle after the request drops
            dma_busy <= loading;
            if (flash_ready && loading) begin
                read_index <= read_index + 24'd4;
                word_count <= word_count + 14'd1;
                // write the word the cycle after it arrives
                wstrb <= 4'b1111;
                if (word_count == flash_load_words - 14'd1) begin
                    loading <= 1'b0;
                end
            end
            // post-increment after each write
            if (wstrb != 4'b0000) begin
                write_addr <= write_addr + 32'd1;
            end
        end
    end

    // always a continued read, the reader opens the stream on the first word
    assign load_req = '{addr: read_index, valid: loading, cont: 1'b1};

    // reader holds rdata until the next word completes
    assign ram_wr = '{addr: write_addr, data: flash_rdata, wstrb: wstrb};

    // write k lands at ram_write_base + k while word_count already reads k + 1
    assert property (@(posedge clk) disable iff (reset)
        (ram_wr.wstrb != 4'b0000) |-> ram_wr.addr == ram_write_base + 32'(word_count) - 32'd1);

endmodule

//--- logic/flash_dma.sv
/*
 * APB read port onto flash, IPL loader instance
 * and the request multiplexer in front of the shared SPI reader
 */

`timescale 1ns/1ps

module flash_dma import flash_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [cpu_addr_w-1:0] paddr,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output ram_wr_t               ram_wr,
    output logic                  dma_busy,
    output flash_req_t            flash_req,
    input  logic                  flash_ready,
    input  logic [31:0]           flash_rdata
);

    flash_req_t  load_req;
    flash_req_t  cpu_req;
    logic        cpu_pending;
    logic [23:0] cpu_addr;
    logic        apb_setup;
    logic        cpu_done;

    // new access seen in the APB setup cycle
    assign apb_setup = psel && !penable && !cpu_pending;
    // the reader only answers the CPU once the loader has let go
    assign cpu_done = cpu_pending && !dma_busy && flash_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            cpu_pending <= 1'b0;
            pready <= 1'b0;
        end else begin
            // pending read waits out the IPL if needed
            if (apb_setup) begin
                cpu_pending <= 1'b1;
            end else if (cpu_done) begin
                cpu_pending <= 1'b0;
            end
            // one-cycle pready, the cycle after reader ready
            pready <= cpu_done;
        end
    end

    always_ff @(posedge clk) begin
        if (apb_setup) begin
            cpu_addr <= flash_user_base + 24'(paddr);
        end
    end

    boot_loader boot_loader_inst (
        .clk         (clk),
        .reset       (reset),
        .flash_ready (flash_ready),
        .flash_rdata (flash_rdata),
        .load_req    (load_req),
        .ram_wr      (ram_wr),
        .dma_busy    (dma_busy)
    );

    // CPU reads are single words, each with its own command
    assign cpu_req = '{addr: cpu_addr, valid: cpu_pending, cont: 1'b0};

    // loader owns the reader until dma_busy falls
    assign flash_req = dma_busy ? load_req : cpu_req;

    // rdata is held by the reader, valid in the pready cycle
    assign prdata = flash_rdata;
    assign pslverr = 1'b0;

    // pready only answers an access phase the master is still holding
    assert property (@(posedge clk) disable iff (reset)
        pready |-> (psel && penable));

    // read-only window, the bus master should never write here
    assert property (@(posedge clk) disable iff (reset)
        (psel && !penable) |-> !pwrite);

endmodule

//--- logic/flash_subsystem.sv
/*
 * boot flash subsystem top: APB and IPL front end plus SPI reader
 */

`timescale 1ns/1ps

module flash_subsystem import flash_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [cpu_addr_w-1:0] paddr,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output ram_wr_t               ram_wr,
    output logic                  dma_busy,
    output logic                  flash_sck,
    output logic                  flash_csn,
    output logic                  flash_mosi,
    input  logic                  flash_miso
);

    // shared reader handshake
    flash_req_t  flash_req;
    logic        flash_ready;
    logic [31:0] flash_rdata;

    flash_dma flash_dma_inst (
        .clk         (clk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .ram_wr      (ram_wr),
        .dma_busy    (dma_busy),
        .flash_req   (flash_req),
        .flash_ready (flash_ready),
        .flash_rdata (flash_rdata)
    );

    spi_flash_reader spi_flash_reader_inst (
        .clk        (clk),
        .reset      (reset),
        .req        (flash_req),
        .ready      (flash_ready),
        .rdata      (flash_rdata),
        .flash_sck  (flash_sck),
        .flash_csn  (flash_csn),
        .flash_mosi (flash_mosi),
        .flash_miso (flash_miso)
    );

endmodule

//--- testbench/tb_clock.sv
/*
 * free-running testbench clock, 100 ns period
 */

`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // low for the first half period, first rising edge at 50 ns
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule

//--- testbench/spi_flash_model.sv
/*
 * behavioral SPI NOR flash, mode 0, read command only
 * answers with bytes from the address data rule and counts commands
 */

`timescale 1ns/1ps

module spi_flash_model (
    input  logic flash_sck,
    input  logic flash_csn,
    input  logic flash_mosi,
    output logic flash_miso,
    output int   cmd_count,
    output int   bad_cmds
);

    logic [31:0] header;
    logic [7:0]  cur_byte;
    int          bit_cnt;
    int          data_bit;

    // byte stored at flash address a
    function automatic logic [7:0] byte_at(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    initial begin
        flash_miso = 1'b0;
        cmd_count = 0;
        bad_cmds = 0;
        header = 32'd0;
        bit_cnt = 0;
        data_bit = 0;
    end

    // deselect ends the stream
    always @(posedge flash_csn) begin
        bit_cnt = 0;
        data_bit = 0;
    end

    // opcode and address shifted in msb first on rising sck
    always @(posedge flash_sck) begin
        if (flash_csn === 1'b0) begin
            if (bit_cnt < 32) begin
                header = {header[30:0], flash_mosi};
            end
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 32) begin
                cmd_count = cmd_count + 1;
                if (header[31:24] != 8'h03) begin
                    bad_cmds = bad_cmds + 1;
                end
            end
        end
    end

    // data goes out on falling sck, ready for the next rising edge
    always @(negedge flash_sck) begin
        if (flash_csn === 1'b0 && bit_cnt >= 32) begin
            cur_byte = byte_at(header[23:0] + 24'(data_bit / 8));
            flash_miso = cur_byte[7 - (data_bit % 8)];
            data_bit = data_bit + 1;
        end
    end

endmodule

//--- testbench/flash_subsystem_tb.sv
/*
 * testbench for the boot flash subsystem: clock, DUT and flash model
 * APB read driver with LFSR offsets, IPL write monitor, data rule model
 * timeout counter and closing summary
 */

`timescale 1ns/1ps

module flash_subsystem_tb import flash_pkg::*; ();

    localparam int read_count = 20;
    // 200 cycles per IPL word, 300 per CPU read (one early read), plus reset
    localparam int cycle_limit = 200 * int'(flash_load_words) + 300 * (read_count + 1) + 16;

    logic                  clk;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [cpu_addr_w-1:0] paddr;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    ram_wr_t               ram_wr;
    logic                  dma_busy;
    logic                  flash_sck;
    logic                  flash_csn;
    logic                  flash_mosi;
    logic                  flash_miso;
    int                    cmd_count;
    int                    bad_cmds;

    logic [15:0] lfsr_state;
    logic [31:0] rand_value;
    int          check_errors = 0;
    int          monitor_errors = 0;
    int          writes_seen = 0;
    int          reads_done = 0;
    int          csn_rises = 0;
    int          cycles = 0;
    logic        busy_fell = 1'b0;

    tb_clock tb_clock_inst (
        .clk (clk)
    );

    flash_subsystem flash_subsystem_inst (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .ram_wr     (ram_wr),
        .dma_busy   (dma_busy),
        .flash_sck  (flash_sck),
        .flash_csn  (flash_csn),
        .flash_mosi (flash_mosi),
        .flash_miso (flash_miso)
    );

    spi_flash_model spi_flash_model_inst (
        .flash_sck  (flash_sck),
        .flash_csn  (flash_csn),
        .flash_mosi (flash_mosi),
        .flash_miso (flash_miso),
        .cmd_count  (cmd_count),
        .bad_cmds   (bad_cmds)
    );

    // flash content: byte a is a[7:0] ^ a[15:8] ^ 0x5a
    function automatic logic [7:0] byte_at(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    // little-endian word, byte a in bits 7:0
    function automatic logic [31:0] rule_word(input logic [23:0] a);
        return {byte_at(a + 24'd3), byte_at(a + 24'd2), byte_at(a + 24'd1), byte_at(a)};
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one LFSR step per bit taken
    task automatic random_bits(input int n, output logic [31:0] value);
        value = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("[ERROR] %s: got %h expected %h", name, got, expected);
        check_errors++;
    endtask

    // APB read, called on a falling edge; new_cmds is the expected flash command count
    task automatic cpu_read(input logic [cpu_addr_w-1:0] offset, input int new_cmds);
        int          rises_before;
        int          cmds_before;
        logic [31:0] expected;
        rises_before = csn_rises;
        cmds_before = cmd_count;
        expected = rule_word(flash_user_base + 24'(offset));
        // setup cycle
        paddr = offset;
        psel = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        while (pready !== 1'b1) @(negedge clk);
        if (prdata !== expected) report_mismatch("prdata", prdata, expected);
        if (dma_busy !== 1'b0) report_mismatch("dma_busy at pready", 32'(dma_busy), 32'd0);
        if (writes_seen != int'(flash_load_words)) begin
            $display("CPU read at offset %h finished before the IPL copy", offset);
            check_errors++;
        end
        if (csn_rises == rises_before) begin
            $display("flash_csn never went high during the CPU read at offset %h", offset);
            check_errors++;
        end
        if (cmd_count - cmds_before != new_cmds) begin
            report_mismatch("flash command count", 32'(cmd_count - cmds_before), 32'(new_cmds));
        end
        @(negedge clk);
        // pready is a single-cycle pulse
        if (pready !== 1'b0) report_mismatch("pready after read", 32'(pready), 32'd0);
        // access completed at the rising edge that saw pready
        psel = 1'b0;
        penable = 1'b0;
        reads_done++;
    endtask

    // IPL write port and dma_busy watcher
    always @(negedge clk) begin
        if (ram_wr.wstrb != 4'b0000) begin
            if (dma_busy !== 1'b1) begin
                $display("RAM write seen after dma_busy fell");
                monitor_errors++;
            end else if (writes_seen >= int'(flash_load_words)) begin
                $display("more RAM writes than the IPL length");
                monitor_errors++;
            end else begin
                if (ram_wr.addr !== ram_write_base + 32'(writes_seen)) begin
                    $display("[ERROR] ram_wr.addr write %0d: got %h expected %h", writes_seen,
                             ram_wr.addr, ram_write_base + 32'(writes_seen));
                    monitor_errors++;
                end
                if (ram_wr.wstrb !== 4'hf) begin
                    $display("[ERROR] ram_wr.wstrb write %0d: got %h expected f", writes_seen,
                             ram_wr.wstrb);
                    monitor_errors++;
                end
                if (ram_wr.data !== rule_word(flash_load_base + 24'(4 * writes_seen))) begin
                    $display("[ERROR] ram_wr.data write %0d: got %h expected %h", writes_seen,
                             ram_wr.data, rule_word(flash_load_base + 24'(4 * writes_seen)));
                    monitor_errors++;
                end
            end
            writes_seen++;
        end
        // busy must only fall once, after the last write
        if (dma_busy === 1'b0 && !busy_fell) begin
            busy_fell = 1'b1;
            if (writes_seen != int'(flash_load_words)) begin
                $display("dma_busy fell after %0d of %0d IPL writes", writes_seen,
                         flash_load_words);
                monitor_errors++;
            end
        end else if (dma_busy === 1'b1 && busy_fell) begin
            $display("dma_busy rose again after the IPL finished");
            monitor_errors++;
            busy_fell = 1'b0;
        end
        if (pslverr !== 1'b0) begin
            $display("[ERROR] pslverr: got %h expected 0", pslverr);
            monitor_errors++;
        end
    end

    always @(posedge flash_csn) begin
        csn_rises++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        lfsr_state = 16'd86;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        repeat (16) @(negedge clk);
        // reset state of the outputs
        if (dma_busy !== 1'b1) report_mismatch("dma_busy in reset", 32'(dma_busy), 32'd1);
        if (ram_wr.wstrb !== 4'h0) report_mismatch("ram_wr.wstrb in reset", 32'(ram_wr.wstrb), 0);
        if (pready !== 1'b0) report_mismatch("pready in reset", 32'(pready), 32'd0);
        if (flash_csn !== 1'b1) report_mismatch("flash_csn in reset", 32'(flash_csn), 32'd1);
        if (flash_sck !== 1'b0) report_mismatch("flash_sck in reset", 32'(flash_sck), 32'd0);
        reset = 1'b0;
        @(negedge clk);
        // early read, stalled behind the IPL; its command follows the IPL one
        if (dma_busy !== 1'b1) begin
            $display("dma_busy already low when the early CPU read was issued");
            check_errors++;
        end
        random_bits(cpu_addr_w, rand_value);
        cpu_read(rand_value[cpu_addr_w-1:0], 2);
        for (int i = 0; i < read_count; i++) begin
            random_bits(cpu_addr_w, rand_value);
            cpu_read(rand_value[cpu_addr_w-1:0], 1);
        end
        if (bad_cmds != 0) report_mismatch("flash opcode errors", 32'(bad_cmds), 32'd0);
        if (writes_seen != int'(flash_load_words)) begin
            report_mismatch("IPL write count", 32'(writes_seen), 32'(flash_load_words));
        end
        $display("summary: %0d ram writes, %0d cpu reads, %0d flash commands, %0d errors",
                 writes_seen, reads_done, cmd_count, check_errors + monitor_errors);
        if (check_errors + monitor_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- files.f
logic/flash_pkg.sv
logic/spi_flash_reader.sv
logic/boot_loader.sv
logic/flash_dma.sv
logic/flash_subsystem.sv
testbench/tb_clock.sv
testbench/spi_flash_model.sv
testbench/flash_subsystem_tb.sv

//--- run.sh
#!/bin/sh
# build and run the flash subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module flash_subsystem_tb -o flash_sim

out=$(./obj_dir/flash_sim)
echo "$out"
echo "$out" | grep -qx "NO ERRORS"
